/* source/cl_counter_macros.svh */
/*
  register map offsets and control bit positions of the counter block
  ID, status and version constants returned on the OCL port
  AXI-Lite response codes and the decoded address width
*/
`ifndef CL_COUNTER_MACROS_SVH
`define CL_COUNTER_MACROS_SVH

`define CL_SH_ID0        32'hC011_1D0F  // vendor / device id word
`define CL_SH_ID1        32'h0C0A_0001  // subsystem id word
`define CL_STATUS0       32'h0000_0FF0  // constant status word
`define CL_VERSION       32'hEEEE_EE00  // build version word

`define OCL_ADDR_LSBS    8              // low byte-address bits that are decoded

`define REG_ID0          8'h00          // ro
`define REG_ID1          8'h04          // ro
`define REG_STATUS       8'h08          // ro
`define REG_VERSION      8'h0C          // ro
`define REG_CTRL         8'h10          // rw, load/clear self-clearing
`define REG_TICK         8'h14          // rw, tick period in bits 7:0
`define REG_LOAD         8'h18          // rw, load value in bits 15:0
`define REG_WMARK        8'h1C          // rw, watermark in bits 15:0
`define REG_COUNT        8'h20          // ro, live counter status

`define CTRL_EN_BIT      0
`define CTRL_LOAD_BIT    1
`define CTRL_CLEAR_BIT   2
`define CTRL_ONESHOT_BIT 3

`define RESP_OKAY        2'd0
`define RESP_SLVERR      2'd2

`endif

/* source/cl_counter_pkg.sv */
/*
  shared types of the counter block
  vector typedefs for bus and counter widths
  register request/response and counter config/status structs
  write and read FSM state encodings
*/
`default_nettype none

`include "cl_counter_macros.svh"

package cl_counter_pkg;

  // ------------------------------
  // plain vectors
  // ------------------------------
  typedef logic [31:0] ocl_addr_t;  // byte address
  typedef logic [31:0] ocl_data_t;  // data word
  typedef logic [3:0]  ocl_strb_t;  // one strobe per byte
  typedef logic [1:0]  axi_resp_t;  // OKAY / SLVERR
  typedef logic [7:0]  tick_t;      // tick period and tick count
  typedef logic [15:0] count_t;     // count, load value, watermark

  // ------------------------------
  // structs
  // ------------------------------
  typedef struct packed {
    logic                        valid;  // one cycle per accepted transfer
    logic                        write;  // 1 = write, 0 = read
    logic [`OCL_ADDR_LSBS-1:0]   addr;   // byte offset within the block
    ocl_data_t                   data;   // write data
    ocl_strb_t                   strb;   // write byte strobes
  } reg_req_t;

  typedef struct packed {
    ocl_data_t data;  // read data, zero on writes and errors
    axi_resp_t resp;
  } reg_rsp_t;

  typedef struct packed {
    logic   enable;
    logic   oneshot;     // saturate instead of wrapping
    logic   load;        // one-cycle pulse
    logic   clear;       // one-cycle pulse
    tick_t  tick_value;
    count_t load_value;
    count_t watermark;
  } cnt_cfg_t;

  typedef struct packed {
    logic   tick;          // prescaler wrapped this cycle
    logic   ge_watermark;  // cnt >= watermark
    tick_t  tick_cnt;
    count_t cnt;
  } cnt_status_t;

  // ------------------------------
  // FSM states
  // ------------------------------
  typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
  typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

endpackage

`default_nettype wire

/* source/ocl_slave.sv */
/*
  AXI-Lite (OCL) slave
  write FSM accepts AW and W together and returns B
  read FSM accepts AR and returns R one cycle later
  both turn accepted transfers into single-cycle register requests
*/
`default_nettype none

`include "cl_counter_macros.svh"

module ocl_slave (
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n,

  // write address
  input  logic                      awvalid,
  input  cl_counter_pkg::ocl_addr_t awaddr,
  output logic                      awready,

  // write data
  input  logic                      wvalid,
  input  cl_counter_pkg::ocl_data_t wdata,
  input  cl_counter_pkg::ocl_strb_t wstrb,
  output logic                      wready,

  // write response
  output logic                      bvalid,
  output cl_counter_pkg::axi_resp_t bresp,
  input  logic                      bready,

  // read address
  input  logic                      arvalid,
  input  cl_counter_pkg::ocl_addr_t araddr,
  output logic                      arready,

  // read data
  output logic                      rvalid,
  output cl_counter_pkg::ocl_data_t rdata,
  output cl_counter_pkg::axi_resp_t rresp,
  input  logic                      rready,

  // register side
  output cl_counter_pkg::reg_req_t  req,
  input  cl_counter_pkg::reg_rsp_t  rsp
);

  import cl_counter_pkg::*;

  wr_state_t wr_state;
  rd_state_t rd_state;
  logic      wr_go;     // write accepted this cycle
  logic      rd_go;     // read accepted this cycle

  // ------------------------------
  // accept decisions
  // ------------------------------
  assign wr_go = (wr_state == WR_IDLE) && awvalid && wvalid;  // needs both channels
  assign rd_go = (rd_state == RD_IDLE) && arvalid && !wr_go;  // write wins a tie

  assign awready = wr_go;  // single-cycle ready pulse
  assign wready  = wr_go;
  assign arready = rd_go;

  assign bvalid = (wr_state == WR_RESP);
  assign rvalid = (rd_state == RD_DATA);

  // ------------------------------
  // register request
  // ------------------------------
  always_comb
  begin
    req.valid = wr_go || rd_go;
    req.write = wr_go;
    req.addr  = wr_go ? awaddr[`OCL_ADDR_LSBS-1:0]  // only low bits decoded
                      : araddr[`OCL_ADDR_LSBS-1:0];
    req.data  = wdata;
    req.strb  = wstrb;
  end

  // ------------------------------
  // write FSM
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      wr_state <= WR_IDLE;
    end
    else
    begin
      case (wr_state)
        WR_IDLE: if (wr_go)  wr_state <= WR_RESP;  // bvalid next edge
        WR_RESP: if (bready) wr_state <= WR_IDLE;  // B handshake done
        default:             wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (wr_go)
    begin
      bresp <= rsp.resp;  // held through WR_RESP
    end
  end

  // ------------------------------
  // read FSM
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      rd_state <= RD_IDLE;
    end
    else
    begin
      case (rd_state)
        RD_IDLE: if (rd_go)  rd_state <= RD_DATA;  // 1-cycle read latency
        RD_DATA: if (rready) rd_state <= RD_IDLE;
        default:             rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (rd_go)
    begin
      rdata <= rsp.data;  // snapshot of status at accept time
      rresp <= rsp.resp;
    end
  end

  // ------------------------------
  // protocol checks
  // ------------------------------
  b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("bvalid/bresp dropped before bready");

  r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("rvalid/rdata dropped before rready");

endmodule

`default_nettype wire

/* source/cnt_csr.sv */
/*
  counter register block
  control, tick, load and watermark registers with byte strobes
  load/clear pulse generation
  read decode of ID, status, version and live count
*/
`default_nettype none

`include "cl_counter_macros.svh"

module cnt_csr (
  input  logic                        clk_main_a0,
  input  logic                        rst_main_n,
  input  cl_counter_pkg::reg_req_t    req,
  output cl_counter_pkg::reg_rsp_t    rsp,
  output cl_counter_pkg::cnt_cfg_t    cfg,
  input  cl_counter_pkg::cnt_status_t status
);

  import cl_counter_pkg::*;

  logic      ctrl_en;
  logic      ctrl_oneshot;
  logic      load_pulse;
  logic      clear_pulse;
  tick_t     tick_value;
  count_t    load_value;
  count_t    watermark;

  ocl_data_t rd_word;   // current value at req.addr
  logic      rd_ok;     // offset is readable
  logic      wr_ok;     // offset is writable
  ocl_data_t merged;    // rd_word with strobed bytes replaced
  logic      wr_fire;

  // byte-lane merge of write data into the current word
  function automatic ocl_data_t merge_bytes(input ocl_data_t cur,
                                            input ocl_data_t wr,
                                            input ocl_strb_t strb);
    ocl_data_t res;
    res = cur;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
      begin
        res[8*i +: 8] = wr[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ------------------------------
  // read decode
  // ------------------------------
  always_comb
  begin
    rd_word = '0;
    rd_ok   = 1'b1;
    wr_ok   = 1'b0;
    case (req.addr)
      `REG_ID0:     rd_word = `CL_SH_ID0;
      `REG_ID1:     rd_word = `CL_SH_ID1;
      `REG_STATUS:  rd_word = `CL_STATUS0;
      `REG_VERSION: rd_word = `CL_VERSION;
      `REG_CTRL:
      begin
        rd_word[`CTRL_EN_BIT]      = ctrl_en;       // load/clear read as 0
        rd_word[`CTRL_ONESHOT_BIT] = ctrl_oneshot;
        wr_ok                      = 1'b1;
      end
      `REG_TICK:
      begin
        rd_word[7:0] = tick_value;
        wr_ok        = 1'b1;
      end
      `REG_LOAD:
      begin
        rd_word[15:0] = load_value;
        wr_ok         = 1'b1;
      end
      `REG_WMARK:
      begin
        rd_word[15:0] = watermark;
        wr_ok         = 1'b1;
      end
      `REG_COUNT:
      begin
        rd_word[15:0]  = status.cnt;          // live, same-cycle view
        rd_word[23:16] = status.tick_cnt;
        rd_word[24]    = status.tick;
        rd_word[25]    = status.ge_watermark;
      end
      default:      rd_ok = 1'b0;            // unmapped
    endcase
  end

  assign merged  = merge_bytes(rd_word, req.data, req.strb);
  assign wr_fire = req.valid && req.write && wr_ok;  // ro/unmapped writes dropped

  // response is combinational, captured by the slave
  assign rsp.data = req.write ? '0 : rd_word;
  assign rsp.resp = (req.write ? wr_ok : rd_ok) ? `RESP_OKAY : `RESP_SLVERR;

  // ------------------------------
  // register updates
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      ctrl_en      <= 1'b0;
      ctrl_oneshot <= 1'b0;
      load_pulse   <= 1'b0;
      clear_pulse  <= 1'b0;
      tick_value   <= '0;
      load_value   <= '0;
      watermark    <= '0;
    end
    else
    begin
      load_pulse  <= wr_fire && (req.addr == `REG_CTRL) && merged[`CTRL_LOAD_BIT];
      clear_pulse <= wr_fire && (req.addr == `REG_CTRL) && merged[`CTRL_CLEAR_BIT];
      if (wr_fire)
      begin
        case (req.addr)
          `REG_CTRL:
          begin
            ctrl_en      <= merged[`CTRL_EN_BIT];
            ctrl_oneshot <= merged[`CTRL_ONESHOT_BIT];
          end
          `REG_TICK:  tick_value <= merged[7:0];
          `REG_LOAD:  load_value <= merged[15:0];
          `REG_WMARK: watermark  <= merged[15:0];
          default:    ;                          // filtered by wr_ok
        endcase
      end
    end
  end

  assign cfg = '{enable:     ctrl_en,
                 oneshot:    ctrl_oneshot,
                 load:       load_pulse,
                 clear:      clear_pulse,
                 tick_value: tick_value,
                 load_value: load_value,
                 watermark:  watermark};

  // one write outstanding in the slave keeps these to single pulses
  pulse_load:  assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    cfg.load |=> !cfg.load)
    else $error("load pulse longer than one cycle");

  pulse_clear: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    cfg.clear |=> !cfg.clear)
    else $error("clear pulse longer than one cycle");

endmodule

`default_nettype wire

/* source/tick_counter.sv */
/*
  tick prescaler and 16-bit main counter
  clear, load, enable, one-shot saturation, watermark compare
*/
`default_nettype none

module tick_counter (
  input  logic                        clk_main_a0,
  input  logic                        rst_main_n,
  input  cl_counter_pkg::cnt_cfg_t    cfg,
  output cl_counter_pkg::cnt_status_t status
);

  import cl_counter_pkg::*;

  tick_t  tick_cnt;
  count_t cnt;
  logic   tick_hit;   // prescaler at or past its period
  logic   cnt_sat;    // one-shot and already at max

  assign tick_hit = cfg.enable && (tick_cnt >= cfg.tick_value);
  assign cnt_sat  = cfg.oneshot && (&cnt);

  // ------------------------------
  // prescaler and main count
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      tick_cnt <= '0;
      cnt      <= '0;
    end
    else if (cfg.clear)
    begin
      tick_cnt <= '0;                         // clear beats everything
      cnt      <= '0;
    end
    else
    begin
      if (cfg.load)
      begin
        cnt <= cfg.load_value;                // load beats counting
      end
      else if (tick_hit && !cnt_sat)
      begin
        cnt <= cnt + count_t'(1);             // wraps unless one-shot
      end

      if (cfg.enable)
      begin
        tick_cnt <= tick_hit ? '0 : tick_cnt + tick_t'(1);
      end
    end
  end

  // ------------------------------
  // status
  // ------------------------------
  assign status.tick         = tick_hit;
  assign status.ge_watermark = (cnt >= cfg.watermark);
  assign status.tick_cnt     = tick_cnt;
  assign status.cnt          = cnt;

endmodule

`default_nettype wire

/* source/cl_counter_top.sv */
/*
  counter block top level
  OCL slave, register block and tick counter
*/
`default_nettype none

module cl_counter_top (
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n,

  input  logic                      awvalid,
  input  cl_counter_pkg::ocl_addr_t awaddr,
  output logic                      awready,

  input  logic                      wvalid,
  input  cl_counter_pkg::ocl_data_t wdata,
  input  cl_counter_pkg::ocl_strb_t wstrb,
  output logic                      wready,

  output logic                      bvalid,
  output cl_counter_pkg::axi_resp_t bresp,
  input  logic                      bready,

  input  logic                      arvalid,
  input  cl_counter_pkg::ocl_addr_t araddr,
  output logic                      arready,

  output logic                      rvalid,
  output cl_counter_pkg::ocl_data_t rdata,
  output cl_counter_pkg::axi_resp_t rresp,
  input  logic                      rready
);

  import cl_counter_pkg::*;

  reg_req_t    req;     // slave -> csr, one cycle per transfer
  reg_rsp_t    rsp;     // csr -> slave, same cycle
  cnt_cfg_t    cfg;     // csr -> counter
  cnt_status_t status;  // counter -> csr

  ocl_slave u_ocl_slave (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .awvalid     (awvalid),
    .awaddr      (awaddr),
    .awready     (awready),
    .wvalid      (wvalid),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wready      (wready),
    .bvalid      (bvalid),
    .bresp       (bresp),
    .bready      (bready),
    .arvalid     (arvalid),
    .araddr      (araddr),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rready      (rready),
    .req         (req),
    .rsp         (rsp)
  );

  cnt_csr u_cnt_csr (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .req         (req),
    .rsp         (rsp),
    .cfg         (cfg),
    .status      (status)
  );

  tick_counter u_tick_counter (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .cfg         (cfg),
    .status      (status)
  );

endmodule

`default_nettype wire

/* verification/cl_counter_tests.svh */
/*
  directed tests of the counter block
  ID words, strobed readback, load and clear, one-shot saturation
  free running count, error responses and read back-pressure
*/

  // expected register contents after a strobed write
  function automatic ocl_data_t apply_strobes(input ocl_data_t old_v, input ocl_data_t new_v,
                                              input ocl_strb_t strb);
    ocl_data_t lanes;
    lanes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~lanes) | (new_v & lanes);
  endfunction

  // ------------------------------
  // constant words
  // ------------------------------
  task automatic read_id_words();
    ocl_data_t data;
    axi_resp_t resp;
    test_name = "id_words";
    ocl_read(`REG_ID0, 0, data, resp);
    check_data("id0", `CL_SH_ID0, data);
    check_resp("id0", `RESP_OKAY, resp);
    ocl_read(`REG_ID1, 0, data, resp);
    check_data("id1", `CL_SH_ID1, data);
    check_resp("id1", `RESP_OKAY, resp);
    ocl_read(`REG_STATUS, 0, data, resp);
    check_data("status", `CL_STATUS0, data);
    check_resp("status", `RESP_OKAY, resp);
    ocl_read(`REG_VERSION, 0, data, resp);
    check_data("version", `CL_VERSION, data);
    check_resp("version", `RESP_OKAY, resp);
  endtask

  // ------------------------------
  // strobed writes with the counter off
  // ------------------------------
  task automatic readback_with_strobes();
    logic [7:0] offs [3];
    ocl_data_t  keep [3];    // bits the register holds
    ocl_data_t  shadow [3];  // expected contents from reset on
    ocl_data_t  wr_data;
    ocl_data_t  strb_bits;
    ocl_data_t  data;
    axi_resp_t  resp;
    test_name = "readback";
    offs[0] = `REG_TICK;
    offs[1] = `REG_LOAD;
    offs[2] = `REG_WMARK;
    keep[0] = 32'h0000_00FF;
    keep[1] = 32'h0000_FFFF;
    keep[2] = 32'h0000_FFFF;
    for (int k = 0; k < 3; k++)
    begin
      shadow[k] = '0;
    end
    for (int n = 0; n < 4; n++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        draw_bits(32, wr_data);
        draw_bits(4, strb_bits);
        ocl_write(offs[k], wr_data, strb_bits[3:0], resp);
        check_resp($sformatf("write 0x%02h", offs[k]), `RESP_OKAY, resp);
        shadow[k] = apply_strobes(shadow[k], wr_data, strb_bits[3:0]) & keep[k];
        ocl_read(offs[k], 0, data, resp);
        check_data($sformatf("reg 0x%02h", offs[k]), shadow[k], data);
        check_resp($sformatf("read 0x%02h", offs[k]), `RESP_OKAY, resp);
      end
    end
    ocl_write(`REG_CTRL, 32'hFFFF_FFFF, 4'hF, resp);  // every bit set
    ocl_read(`REG_CTRL, 0, data, resp);
    check_data("ctrl", (32'd1 << `CTRL_EN_BIT) | (32'd1 << `CTRL_ONESHOT_BIT), data);
    ocl_write(`REG_CTRL, 32'h0, 4'hF, resp);
  endtask

  // ------------------------------
  // load, watermark, clear
  // ------------------------------
  task automatic load_and_clear();
    ocl_data_t rnd;
    count_t    load_v;
    count_t    wmark_v;
    ocl_data_t data;
    axi_resp_t resp;
    test_name = "load_clear";
    ocl_write(`REG_TICK, 32'h0000_00FF, 4'hF, resp);  // slowest prescaler
    ocl_write(`REG_CTRL, (32'd1 << `CTRL_CLEAR_BIT) | (32'd1 << `CTRL_EN_BIT), 4'hF, resp);
    ocl_write(`REG_CTRL, 32'h0, 4'hF, resp);  // tick_cnt left a few steps above zero
    for (int n = 0; n < 3; n++)
    begin
      draw_bits(16, rnd);
      load_v = rnd[15:0];
      draw_bits(16, rnd);
      wmark_v = (n == 2) ? load_v : rnd[15:0];  // last round right on the threshold
      ocl_write(`REG_LOAD, ocl_data_t'(load_v), 4'hF, resp);
      ocl_write(`REG_WMARK, ocl_data_t'(wmark_v), 4'hF, resp);
      ocl_write(`REG_CTRL, 32'd1 << `CTRL_LOAD_BIT, 4'hF, resp);
      ocl_read(`REG_COUNT, 0, data, resp);
      check_count("cnt after load", load_v, data[15:0]);
      check_data("ge_watermark", ocl_data_t'(load_v >= wmark_v), ocl_data_t'(data[25]));
    end
    ocl_write(`REG_CTRL, 32'd1 << `CTRL_CLEAR_BIT, 4'hF, resp);
    ocl_read(`REG_COUNT, 0, data, resp);
    check_count("cnt after clear", '0, data[15:0]);
    check_count("tick_cnt after clear", '0, count_t'(data[23:16]));
  endtask

  // ------------------------------
  // one-shot stops at max
  // ------------------------------
  task automatic oneshot_saturate();
    ocl_data_t os_bit;
    ocl_data_t en_bit;
    ocl_data_t data;
    axi_resp_t resp;
    test_name = "oneshot";
    os_bit = 32'd1 << `CTRL_ONESHOT_BIT;
    en_bit = 32'd1 << `CTRL_EN_BIT;
    ocl_write(`REG_TICK, 32'h0, 4'hF, resp);  // tick every cycle
    ocl_write(`REG_LOAD, 32'h0000_FFFE, 4'hF, resp);
    ocl_write(`REG_CTRL, os_bit | (32'd1 << `CTRL_LOAD_BIT), 4'hF, resp);
    ocl_write(`REG_CTRL, os_bit | en_bit, 4'hF, resp);
    repeat (20) @(negedge clk_main_a0);
    ocl_write(`REG_CTRL, os_bit, 4'hF, resp);
    ocl_read(`REG_COUNT, 0, data, resp);
    check_count("cnt stopped", 16'hFFFF, data[15:0]);
    check_data("tick while disabled", 32'h0, ocl_data_t'(data[24]));
    ocl_write(`REG_CTRL, os_bit | en_bit, 4'hF, resp);
    for (int n = 0; n < 2; n++)
    begin
      ocl_read(`REG_COUNT, 0, data, resp);
      check_count("cnt held while enabled", 16'hFFFF, data[15:0]);
      check_data("tick while enabled", 32'h1, ocl_data_t'(data[24]));  // period 0
    end
    ocl_write(`REG_CTRL, 32'h0, 4'hF, resp);
  endtask

  // ------------------------------
  // wrapping mode with a random period
  // ------------------------------
  task automatic free_running_count();
    ocl_data_t rnd;
    ocl_data_t data;
    tick_t     tick_v;
    count_t    first_cnt;
    int        gap;
    axi_resp_t resp;
    test_name = "free_run";
    draw_bits(8, rnd);
    tick_v = rnd[7:0];
    ocl_write(`REG_TICK, ocl_data_t'(tick_v), 4'hF, resp);
    ocl_write(`REG_LOAD, 32'h0, 4'hF, resp);
    ocl_write(`REG_CTRL, (32'd1 << `CTRL_LOAD_BIT) | (32'd1 << `CTRL_CLEAR_BIT), 4'hF, resp);
    ocl_write(`REG_CTRL, 32'd1 << `CTRL_EN_BIT, 4'hF, resp);
    ocl_read(`REG_COUNT, 0, data, resp);
    first_cnt = data[15:0];
    check_at_most("first tick_cnt", count_t'(tick_v), count_t'(data[23:16]));
    draw_bits(4, rnd);
    gap = int'(rnd[3:0]) + 4;
    repeat (gap) @(negedge clk_main_a0);
    ocl_read(`REG_COUNT, 0, data, resp);
    check_at_most("second tick_cnt", count_t'(tick_v), count_t'(data[23:16]));
    check_at_most("first cnt vs second", data[15:0], first_cnt);  // no decrease
    ocl_write(`REG_CTRL, 32'h0, 4'hF, resp);
  endtask

  // ------------------------------
  // SLVERR and rready stalls
  // ------------------------------
  task automatic error_responses();
    ocl_data_t data;
    axi_resp_t resp;
    test_name = "errors";
    ocl_read(8'h24, 0, data, resp);
    check_resp("unmapped 0x24", `RESP_SLVERR, resp);
    check_data("unmapped 0x24", 32'h0, data);
    ocl_read(8'hFC, 0, data, resp);
    check_resp("unmapped 0xfc", `RESP_SLVERR, resp);
    check_data("unmapped 0xfc", 32'h0, data);
    ocl_write(`REG_ID0, 32'h1234_5678, 4'hF, resp);
    check_resp("write id0", `RESP_SLVERR, resp);
    ocl_read(`REG_ID0, 3, data, resp);  // id0 untouched by the write
    check_data("id0 stalled", `CL_SH_ID0, data);
    check_resp("id0 stalled", `RESP_OKAY, resp);
    ocl_read(`REG_VERSION, 5, data, resp);
    check_data("version stalled", `CL_VERSION, data);
    check_resp("version stalled", `RESP_OKAY, resp);
    ocl_write(`REG_WMARK, 32'h0000_A5C3, 4'hF, resp);
    ocl_read(`REG_WMARK, 6, data, resp);
    check_data("wmark stalled", 32'h0000_A5C3, data);
    check_resp("wmark stalled", `RESP_OKAY, resp);
  endtask

/* verification/tb_cl_counter.sv */
/*
  testbench top for the counter block
  clock, reset, DUT, Galois LFSR stimulus source
  OCL bus tasks, compare tasks, run timeout and final verdict
*/
`default_nettype none

`include "cl_counter_macros.svh"

`define TB_TIMEOUT_CYCLES 5000  // tests need roughly 300 cycles, wide margin

module tb_cl_counter;

  import cl_counter_pkg::*;

  logic        clk_main_a0;
  logic        rst_main_n;
  logic        awvalid;
  ocl_addr_t   awaddr;
  logic        awready;
  logic        wvalid;
  ocl_data_t   wdata;
  ocl_strb_t   wstrb;
  logic        wready;
  logic        bvalid;
  axi_resp_t   bresp;
  logic        bready;
  logic        arvalid;
  ocl_addr_t   araddr;
  logic        arready;
  logic        rvalid;
  ocl_data_t   rdata;
  axi_resp_t   rresp;
  logic        rready;

  string       test_name;       // shown in error lines
  logic [15:0] lfsr;            // stimulus state
  int          cycle_cnt = 0;

  cl_counter_top i_dut (.*);

  initial
  begin
    clk_main_a0 = 1'b0;
    forever #5 clk_main_a0 = ~clk_main_a0;  // period 10
  end

  // ------------------------------
  // failure handling
  // ------------------------------
  task automatic abort_run(input string reason);
    $display("tests failed");
    $fatal(1, "%s", reason);
  endtask

  always @(posedge clk_main_a0)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == `TB_TIMEOUT_CYCLES)
    begin
      $display("run timed out after %0d cycles, the tests did not finish", cycle_cnt);
      abort_run("timeout");
    end
  end

  task automatic check_data(input string what, input ocl_data_t exp, input ocl_data_t act);
    if (act !== exp)
    begin
      $display("FAIL %s %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
      abort_run("data mismatch");
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp)
    begin
      $display("FAIL %s %s: expected resp %0d, actual resp %0d", test_name, what, exp, act);
      abort_run("response mismatch");
    end
  endtask

  task automatic check_count(input string what, input count_t exp, input count_t act);
    if (act !== exp)
    begin
      $display("FAIL %s %s: expected 0x%04h, actual 0x%04h", test_name, what, exp, act);
      abort_run("count mismatch");
    end
  endtask

  // upper bound on a count, used where only an order is known
  task automatic check_at_most(input string what, input count_t limit, input count_t act);
    if (act > limit)
    begin
      $display("FAIL %s %s: expected <= 0x%04h, actual 0x%04h", test_name, what, limit, act);
      abort_run("count above bound");
    end
  endtask

  // ------------------------------
  // stimulus source
  // ------------------------------
  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output ocl_data_t val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  // ------------------------------
  // OCL bus tasks
  // ------------------------------
  task automatic ocl_write(input logic [`OCL_ADDR_LSBS-1:0] offset, input ocl_data_t data,
                           input ocl_strb_t strb, output axi_resp_t resp);
    @(negedge clk_main_a0);
    awaddr  = ocl_addr_t'(offset);
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(posedge clk_main_a0);
    while (!(awready && wready)) @(posedge clk_main_a0);  // AW and W taken together
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(posedge clk_main_a0);
    while (!bvalid) @(posedge clk_main_a0);
    resp = bresp;
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  // stall = cycles that rready stays low after the address is taken
  task automatic ocl_read(input logic [`OCL_ADDR_LSBS-1:0] offset, input int stall,
                          output ocl_data_t data, output axi_resp_t resp);
    @(negedge clk_main_a0);
    araddr  = ocl_addr_t'(offset);
    arvalid = 1'b1;
    rready  = (stall == 0);
    @(posedge clk_main_a0);
    while (!arready) @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    repeat (stall) @(negedge clk_main_a0);  // R must be held meanwhile
    rready = 1'b1;
    @(posedge clk_main_a0);
    while (!rvalid) @(posedge clk_main_a0);
    data = rdata;
    resp = rresp;
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  `include "cl_counter_tests.svh"

  // ------------------------------
  // run
  // ------------------------------
  initial
  begin
    rst_main_n = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    bready     = 1'b0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b0;
    lfsr       = 16'd61;  // seed
    test_name  = "reset";
    repeat (3) @(negedge clk_main_a0);  // three rising edges in reset
    rst_main_n = 1'b1;

    read_id_words();
    readback_with_strobes();
    load_and_clear();
    oneshot_saturate();
    free_running_count();
    error_responses();

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
+incdir+verification
source/cl_counter_pkg.sv
source/ocl_slave.sv
source/cnt_csr.sv
source/tick_counter.sv
source/cl_counter_top.sv
verification/tb_cl_counter.sv

/* Makefile */
# Verilator build and run of the counter block testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_cl_counter
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
